/* common/cap_charge_pkg.sv */
`default_nettype none

package cap_charge_pkg;

   // --------------------
   // widths
   localparam int NUM_CH = 3;   // charge channels

   typedef logic [7:0]        byte_t;
   typedef logic [7:0]        setpoint_t;   // compared with sample[13:6]
   typedef logic [13:0]       sample_t;
   typedef logic [NUM_CH-1:0] ch_mask_t;    // one bit per channel

   // --------------------
   // bundles
   typedef struct packed {
      logic                     valid;   // one strobe for all channels
      sample_t [NUM_CH-1:0]     sample;
   } adc_bus_t;

   typedef struct packed {
      ch_mask_t fault;   // driver fault
      ch_mask_t error;   // both driver inputs high
   } drv_status_t;

   typedef struct packed {
      logic  req;    // held until grant
      byte_t data;
   } tx_req_t;

   // --------------------
   // frame and report codes
   localparam byte_t FRAME_HDR    = 8'hA5;
   localparam byte_t CMD_SET_BASE = 8'h01;   // 01..03 set channel 0..2
   localparam byte_t CMD_START    = 8'h10;
   localparam byte_t CMD_STOP     = 8'h20;
   localparam byte_t CMD_CLEAR    = 8'h30;
   localparam byte_t ACK_BAD      = 8'hEE;
   localparam byte_t RPT_DONE     = 8'h80;   // plus channel
   localparam byte_t RPT_FAULT    = 8'h90;   // plus channel

   // state machines
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;
   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
   typedef enum logic [1:0] {P_HDR, P_CMD, P_ARG} parse_state_e;

endpackage

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx
   import cap_charge_pkg::*;
#(
   parameter int CLK_FREQ = 25_000_000,
   parameter int UART_BPS = 1_000_000
) (
   input  wire logic sys_clk,
   input  wire logic arst_n,
   input  wire logic uart_rxd,   // idles high
   output byte_t     rx_data,
   output logic      rx_done     // mid stop bit
);

   localparam int BAUD_CNT = CLK_FREQ / UART_BPS;   // clocks per bit
   localparam int CNT_W    = $clog2(BAUD_CNT);

   rx_state_e        state;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_idx;
   logic             rxd_s1;
   logic             rxd_s2;
   byte_t            shift;
   logic             half_end;   // middle of start bit
   logic             bit_end;    // one full bit later

   assign half_end = (baud_cnt == CNT_W'(BAUD_CNT / 2 - 1));
   assign bit_end  = (baud_cnt == CNT_W'(BAUD_CNT - 1));

   // two-flop sync, line idles high
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         rxd_s1 <= 1'b1;
         rxd_s2 <= 1'b1;
      end else begin
         rxd_s1 <= uart_rxd;
         rxd_s2 <= rxd_s1;
      end
   end

   // --------------------
   // bit timing FSM
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= RX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         rx_done  <= 1'b0;
      end else begin
         rx_done  <= 1'b0;
         baud_cnt <= baud_cnt + 1'b1;
         case (state)
            RX_IDLE: begin
               baud_cnt <= '0;
               if (!rxd_s2) state <= RX_START;   // falling edge
            end
            RX_START: begin
               if (half_end) begin
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  state    <= rxd_s2 ? RX_IDLE : RX_DATA;   // glitch check
               end
            end
            RX_DATA: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  bit_idx  <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) state <= RX_STOP;
               end
            end
            RX_STOP: begin
               if (bit_end) begin
                  state   <= RX_IDLE;
                  rx_done <= rxd_s2;   // low stop bit drops byte
               end
            end
            default: state <= RX_IDLE;
         endcase
      end
   end

   // data path
   always_ff @(posedge sys_clk) begin
      if (state == RX_DATA && bit_end) shift <= {rxd_s2, shift[7:1]};   // lsb first
      if (state == RX_STOP && bit_end && rxd_s2) rx_data <= shift;
   end

endmodule

`default_nettype wire

/* uart/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx
   import cap_charge_pkg::*;
#(
   parameter int CLK_FREQ = 25_000_000,
   parameter int UART_BPS = 1_000_000
) (
   input  wire logic  sys_clk,
   input  wire logic  arst_n,
   input  wire logic  tx_start,   // one cycle, sampled when idle
   input  wire byte_t tx_data,
   output logic       uart_txd,
   output logic       busy
);

   localparam int BAUD_CNT = CLK_FREQ / UART_BPS;
   localparam int CNT_W    = $clog2(BAUD_CNT);

   tx_state_e        state;
   logic [CNT_W-1:0] baud_cnt;
   logic [2:0]       bit_idx;
   byte_t            shift;   // frame being sent
   logic             bit_end;

   assign bit_end = (baud_cnt == CNT_W'(BAUD_CNT - 1));
   assign busy    = (state != TX_IDLE);   // start edge to end of stop bit

   // --------------------
   // frame FSM
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state    <= TX_IDLE;
         baud_cnt <= '0;
         bit_idx  <= '0;
         uart_txd <= 1'b1;
      end else begin
         baud_cnt <= baud_cnt + 1'b1;
         case (state)
            TX_IDLE: begin
               baud_cnt <= '0;
               if (tx_start) begin
                  state    <= TX_START;
                  uart_txd <= 1'b0;   // start bit
               end
            end
            TX_START: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  bit_idx  <= '0;
                  state    <= TX_DATA;
                  uart_txd <= shift[0];
               end
            end
            TX_DATA: begin
               if (bit_end) begin
                  baud_cnt <= '0;
                  bit_idx  <= bit_idx + 1'b1;
                  if (bit_idx == 3'd7) begin
                     state    <= TX_STOP;
                     uart_txd <= 1'b1;   // stop bit
                  end else begin
                     uart_txd <= shift[bit_idx + 3'd1];
                  end
               end
            end
            TX_STOP: if (bit_end) state <= TX_IDLE;
            default: state <= TX_IDLE;
         endcase
      end
   end

   always_ff @(posedge sys_clk) begin
      if (state == TX_IDLE && tx_start) shift <= tx_data;   // captured once per frame
   end

endmodule

`default_nettype wire

/* uart/tx_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module tx_arbiter
   import cap_charge_pkg::*;
(
   input  wire logic    sys_clk,
   input  wire logic    arst_n,
   input  wire tx_req_t ack_req,
   input  wire tx_req_t rpt_req,     // wins over ack
   input  wire logic    busy,
   output logic         ack_grant,
   output logic         rpt_grant,
   output logic         tx_start,
   output byte_t        tx_data
);

   logic free;   // transmitter can take a byte

   // tx_start high means busy has not risen yet
   assign free = !busy && !tx_start;

   // --------------------
   // fixed priority grant
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         ack_grant <= 1'b0;
         rpt_grant <= 1'b0;
         tx_start  <= 1'b0;
      end else begin
         ack_grant <= 1'b0;
         rpt_grant <= 1'b0;
         tx_start  <= 1'b0;
         if (free && rpt_req.req) begin
            rpt_grant <= 1'b1;
            tx_start  <= 1'b1;
         end else if (free && ack_req.req) begin
            ack_grant <= 1'b1;
            tx_start  <= 1'b1;
         end
      end
   end

   // byte goes out at the grant edge
   always_ff @(posedge sys_clk) begin
      if (free && rpt_req.req) tx_data <= rpt_req.data;
      else if (free && ack_req.req) tx_data <= ack_req.data;
   end

endmodule

`default_nettype wire

/* hdl/cmd_parser.sv */
`timescale 1ns/1ps
`default_nettype none

module cmd_parser
   import cap_charge_pkg::*;
(
   input  wire logic       sys_clk,
   input  wire logic       arst_n,
   input  wire byte_t      rx_data,
   input  wire logic       rx_done,
   input  wire logic       ack_grant,
   output setpoint_t [NUM_CH-1:0] setpoint,
   output ch_mask_t        start_mask,   // strobe
   output logic            stop,         // strobe
   output ch_mask_t        clear_mask,   // strobe
   output tx_req_t         ack_req
);

   localparam int IDX_W = $clog2(NUM_CH);

   parse_state_e state;
   byte_t        cmd;       // command byte of current frame
   byte_t        set_idx;
   logic         is_set;    // setpoint command

   assign set_idx = cmd - CMD_SET_BASE;
   assign is_set  = (set_idx < byte_t'(NUM_CH));   // codes below base wrap high

   // --------------------
   // frame walk and execute
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         state      <= P_HDR;
         setpoint   <= '0;
         start_mask <= '0;
         stop       <= 1'b0;
         clear_mask <= '0;
         ack_req    <= '0;
      end else begin
         start_mask <= '0;
         stop       <= 1'b0;
         clear_mask <= '0;
         if (ack_grant) ack_req.req <= 1'b0;   // taken by arbiter
         if (rx_done) begin
            case (state)
               P_HDR: if (rx_data == FRAME_HDR) state <= P_CMD;   // else stay
               P_CMD: state <= P_ARG;
               P_ARG: begin
                  state        <= P_HDR;
                  ack_req.req  <= 1'b1;    // newer ack replaces a pending one
                  ack_req.data <= cmd;     // echo
                  if (is_set) begin
                     setpoint[set_idx[IDX_W-1:0]] <= rx_data;
                  end else if (cmd == CMD_START) begin
                     start_mask <= rx_data[NUM_CH-1:0];
                  end else if (cmd == CMD_STOP) begin
                     stop <= 1'b1;   // argument ignored
                  end else if (cmd == CMD_CLEAR) begin
                     clear_mask <= rx_data[NUM_CH-1:0];
                  end else begin
                     ack_req.data <= ACK_BAD;
                  end
               end
               default: state <= P_HDR;
            endcase
         end
      end
   end

   always_ff @(posedge sys_clk) begin
      if (rx_done && state == P_CMD) cmd <= rx_data;
   end

endmodule

`default_nettype wire

/* hdl/charge_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module charge_ctrl
   import cap_charge_pkg::*;
#(
   parameter int RESET_CYCLES = 16   // driver reset pulse length
) (
   input  wire logic        sys_clk,
   input  wire logic        arst_n,
   input  wire setpoint_t [NUM_CH-1:0] setpoint,
   input  wire ch_mask_t    start_mask,
   input  wire logic        stop,
   input  wire ch_mask_t    clear_mask,
   input  wire adc_bus_t    adc,
   input  wire drv_status_t drv,         // asynchronous to sys_clk
   output ch_mask_t         igbt,
   output ch_mask_t         drv_reset,
   output ch_mask_t         done_evt,
   output ch_mask_t         fault_evt
);

   localparam int CNT_W = $clog2(RESET_CYCLES + 1);

   drv_status_t      drv_s1;
   drv_status_t      drv_s2;
   ch_mask_t         bad;       // synced fault or error
   ch_mask_t         hit;       // sample reached setpoint
   ch_mask_t         latch;     // fault latch
   logic [CNT_W-1:0] rst_cnt [NUM_CH];

   // --------------------
   // driver status sync
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         drv_s1 <= '0;
         drv_s2 <= '0;
      end else begin
         drv_s1 <= drv;
         drv_s2 <= drv_s1;
      end
   end

   always_comb begin
      bad = drv_s2.fault | drv_s2.error;
      for (int i = 0; i < NUM_CH; i++) begin
         hit[i]       = adc.valid && (adc.sample[i][13:6] >= setpoint[i]);   // top 8 bits
         drv_reset[i] = (rst_cnt[i] != '0);
      end
   end

   // --------------------
   // per channel sequencer
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         igbt      <= '0;
         latch     <= '0;
         done_evt  <= '0;
         fault_evt <= '0;
         for (int i = 0; i < NUM_CH; i++) rst_cnt[i] <= '0;
      end else begin
         for (int i = 0; i < NUM_CH; i++) begin
            done_evt[i]  <= igbt[i] & hit[i] & ~bad[i] & ~stop;
            fault_evt[i] <= bad[i] & ~latch[i];   // once per latch

            // stop and faults first, then setpoint reached, then start
            if (stop || bad[i]) begin
               igbt[i] <= 1'b0;
            end else if (igbt[i] && hit[i]) begin
               igbt[i] <= 1'b0;
            end else if (start_mask[i] && !latch[i]) begin
               igbt[i] <= 1'b1;
            end

            // driver reset pulse
            if (rst_cnt[i] != '0) begin
               rst_cnt[i] <= rst_cnt[i] - 1'b1;
            end else if (clear_mask[i] && latch[i]) begin
               rst_cnt[i] <= CNT_W'(RESET_CYCLES);
            end

            // latch reopens only at end of pulse with status low
            if (bad[i]) begin
               latch[i] <= 1'b1;
            end else if (rst_cnt[i] == CNT_W'(1)) begin
               latch[i] <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/event_reporter.sv */
`timescale 1ns/1ps
`default_nettype none

module event_reporter
   import cap_charge_pkg::*;
(
   input  wire logic     sys_clk,
   input  wire logic     arst_n,
   input  wire ch_mask_t done_evt,
   input  wire ch_mask_t fault_evt,
   input  wire logic     rpt_grant,
   output tx_req_t       rpt_req
);

   localparam int NUM_EV = 2 * NUM_CH;
   localparam int SEL_W  = $clog2(NUM_EV);

   logic [NUM_EV-1:0] pend;   // {fault, done}
   logic [NUM_EV-1:0] clr;
   logic [SEL_W-1:0]  pick;   // lowest pending
   logic [SEL_W-1:0]  sel;    // bit behind the offered byte
   byte_t             pick_byte;

   always_comb begin
      pick = '0;
      for (int k = NUM_EV - 1; k >= 0; k--) begin
         if (pend[k]) pick = SEL_W'(k);   // lowest index wins
      end
      if (pick < SEL_W'(NUM_CH)) pick_byte = RPT_DONE + byte_t'(pick);
      else pick_byte = RPT_FAULT + byte_t'(pick - SEL_W'(NUM_CH));
      clr = '0;
      if (rpt_grant) clr[sel] = 1'b1;
   end

   // --------------------
   // pending bits and offer
   always_ff @(posedge sys_clk or negedge arst_n) begin
      if (!arst_n) begin
         pend    <= '0;
         sel     <= '0;
         rpt_req <= '0;
      end else begin
         pend <= (pend & ~clr) | {fault_evt, done_evt};   // new events survive clear
         if (rpt_grant) begin
            rpt_req.req <= 1'b0;
         end else if (!rpt_req.req && |pend) begin
            rpt_req.req  <= 1'b1;
            rpt_req.data <= pick_byte;   // frozen until grant
            sel          <= pick;
         end
      end
   end

endmodule

`default_nettype wire

/* hdl/cap_charge_top.sv */
`timescale 1ns/1ps
`default_nettype none

module cap_charge_top
   import cap_charge_pkg::*;
#(
   parameter int CLK_FREQ     = 25_000_000,
   parameter int UART_BPS     = 1_000_000,
   parameter int RESET_CYCLES = 16
) (
   input  wire logic        sys_clk,
   input  wire logic        arst_n,
   input  wire logic        uart_rxd,
   input  wire adc_bus_t    adc,
   input  wire drv_status_t drv,
   output logic             uart_txd,
   output ch_mask_t         igbt,
   output ch_mask_t         drv_reset
);

   byte_t                 rx_data;
   logic                  rx_done;
   setpoint_t [NUM_CH-1:0] setpoint;
   ch_mask_t              start_mask;
   logic                  stop;
   ch_mask_t              clear_mask;
   ch_mask_t              done_evt;
   ch_mask_t              fault_evt;
   tx_req_t               ack_req;
   tx_req_t               rpt_req;
   logic                  ack_grant;
   logic                  rpt_grant;
   logic                  tx_start;
   byte_t                 tx_data;
   logic                  busy;

   // --------------------
   // host link
   uart_rx #(
      .CLK_FREQ (CLK_FREQ),
      .UART_BPS (UART_BPS)
   ) u_uart_rx (
      .sys_clk  (sys_clk),
      .arst_n   (arst_n),
      .uart_rxd (uart_rxd),
      .rx_data  (rx_data),
      .rx_done  (rx_done)
   );

   cmd_parser u_cmd_parser (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .rx_data    (rx_data),
      .rx_done    (rx_done),
      .ack_grant  (ack_grant),
      .setpoint   (setpoint),
      .start_mask (start_mask),
      .stop       (stop),
      .clear_mask (clear_mask),
      .ack_req    (ack_req)
   );

   // --------------------
   // charge channels
   charge_ctrl #(
      .RESET_CYCLES (RESET_CYCLES)
   ) u_charge_ctrl (
      .sys_clk    (sys_clk),
      .arst_n     (arst_n),
      .setpoint   (setpoint),
      .start_mask (start_mask),
      .stop       (stop),
      .clear_mask (clear_mask),
      .adc        (adc),
      .drv        (drv),
      .igbt       (igbt),
      .drv_reset  (drv_reset),
      .done_evt   (done_evt),
      .fault_evt  (fault_evt)
   );

   event_reporter u_event_reporter (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .done_evt  (done_evt),
      .fault_evt (fault_evt),
      .rpt_grant (rpt_grant),
      .rpt_req   (rpt_req)
   );

   // --------------------
   // shared transmitter
   tx_arbiter u_tx_arbiter (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .ack_req   (ack_req),
      .rpt_req   (rpt_req),
      .busy      (busy),
      .ack_grant (ack_grant),
      .rpt_grant (rpt_grant),
      .tx_start  (tx_start),
      .tx_data   (tx_data)
   );

   uart_tx #(
      .CLK_FREQ (CLK_FREQ),
      .UART_BPS (UART_BPS)
   ) u_uart_tx (
      .sys_clk  (sys_clk),
      .arst_n   (arst_n),
      .tx_start (tx_start),
      .tx_data  (tx_data),
      .uart_txd (uart_txd),
      .busy     (busy)
   );

endmodule

`default_nettype wire

/* bench/tb_cap_charge.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_cap_charge
   import cap_charge_pkg::*;
;

   localparam int BIT_CLKS   = 25;     // 25 MHz / 1 Mbaud
   localparam int RX_TIMEOUT = 1500;   // room for three queued frames
   localparam logic [7:0] SP0 = 8'h40;
   localparam logic [7:0] SP1 = 8'h60;
   localparam logic [7:0] SP2 = 8'h80;

   logic        sys_clk;
   logic        arst_n;
   logic        uart_rxd;
   logic        uart_txd;
   adc_bus_t    adc;
   drv_status_t drv;
   ch_mask_t    igbt;
   ch_mask_t    drv_reset;
   logic [7:0]  rx_q [$];   // bytes decoded from uart_txd
   logic        rx_active;  // monitor inside a frame
   int unsigned seed_used;

   cap_charge_top dut0 (
      .sys_clk   (sys_clk),
      .arst_n    (arst_n),
      .uart_rxd  (uart_rxd),
      .adc       (adc),
      .drv       (drv),
      .uart_txd  (uart_txd),
      .igbt      (igbt),
      .drv_reset (drv_reset)
   );

   initial begin
      sys_clk = 1'b0;
      forever #20 sys_clk = ~sys_clk;   // 40 ns
   end

   // --------------------
   // failure reporting
   task automatic stop_failed();
      $display("*** FAILED ***");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic value_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
      $display("[ERROR] %s = %h, expected %h at %0t", name, got, exp, $time);
      stop_failed();
   endtask

   task automatic error_msg(input string msg);
      $display("[ERROR] %s at %0t", msg, $time);
      stop_failed();
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else value_mismatch(name, got, exp);
   endtask

   // a channel whose driver reports trouble never turns on
   no_start_on_fault: assert property (@(posedge sys_clk) disable iff (!arst_n)
      (igbt & ~$past(igbt) & (drv.fault | drv.error)) == '0)
      else error_msg("igbt turned on while its driver reported a fault");

   // --------------------
   // timing helpers
   task automatic ticks(input int n);
      repeat (n) begin
         @(posedge sys_clk);
         #2;   // drive and sample point
      end
   endtask

   task automatic send_byte(input logic [7:0] b);
      uart_rxd = 1'b0;   // start bit
      ticks(BIT_CLKS);
      for (int i = 0; i < 8; i++) begin
         uart_rxd = b[i];   // lsb first
         ticks(BIT_CLKS);
      end
      uart_rxd = 1'b1;
      ticks(BIT_CLKS);
   endtask

   task automatic send_frame(input logic [7:0] b0, input logic [7:0] b1, input logic [7:0] b2);
      send_byte(b0);
      send_byte(b1);
      send_byte(b2);
      ticks(5);   // short idle gap
   endtask

   task automatic expect_byte(input logic [7:0] exp);
      int n;
      logic [7:0] got;
      n = 0;
      while (rx_q.size() == 0 && n < RX_TIMEOUT) begin
         ticks(1);
         n++;
      end
      assert (rx_q.size() != 0)
         else error_msg($sformatf("no byte on uart_txd, waited for %h", exp));
      got = rx_q.pop_front();
      check_eq("uart_txd byte", got, exp);
   endtask

   // nothing sent and nothing in flight
   task automatic expect_silence(input int n);
      for (int i = 0; i < n; i++) begin
         ticks(1);
         assert (rx_q.size() == 0 && !rx_active)
            else error_msg("unexpected byte on uart_txd");
      end
   endtask

   task automatic wait_igbt(input ch_mask_t exp);
      int n;
      n = 0;
      while (igbt !== exp && n < 100) begin
         ticks(1);
         n++;
      end
      check_eq("igbt", igbt, exp);
   endtask

   task automatic wait_tx_active();
      int n;
      n = 0;
      while (!rx_active && n < 200) begin
         ticks(1);
         n++;
      end
      assert (rx_active) else error_msg("uart_txd never started a frame");
   endtask

   // fault edge to igbt low in at most 4 cycles
   task automatic wait_channel_off(input int ch);
      int n;
      n = 0;
      while (igbt[ch] && n < 4) begin
         ticks(1);
         n++;
      end
      assert (!igbt[ch])
         else error_msg($sformatf("igbt[%0d] still on 4 cycles after driver fault", ch));
   endtask

   task automatic measure_reset(input int ch, input int exp_len);
      int n;
      int len;
      n   = 0;
      len = 0;
      while (!drv_reset[ch] && n < 1000) begin
         ticks(1);
         n++;
      end
      assert (drv_reset[ch]) else error_msg("drv_reset pulse never started");
      while (drv_reset[ch] && len < 100) begin
         check_eq("drv_reset", drv_reset, 32'(1) << ch);   // only this channel
         ticks(1);
         len++;
      end
      check_eq("drv_reset pulse length", len, exp_len);
   endtask

   // --------------------
   // adc stimulus
   function automatic sample_t below_sp(input logic [7:0] sp);
      below_sp = sample_t'($urandom % (32'(sp) * 64));   // top bits under sp
   endfunction

   function automatic sample_t above_sp(input logic [7:0] sp);
      logic [7:0] top;
      top      = sp + 8'($urandom % (256 - 32'(sp)));   // sp..ff
      above_sp = {top, 6'($urandom % 64)};
   endfunction

   function automatic sample_t at_sp(input logic [7:0] sp);
      at_sp = {sp, 6'($urandom % 64)};   // top bits equal sp
   endfunction

   task automatic adc_pulse(input sample_t s0, input sample_t s1, input sample_t s2);
      adc.sample[0] = s0;
      adc.sample[1] = s1;
      adc.sample[2] = s2;
      adc.valid     = 1'b1;
      ticks(1);   // compare lands on this edge
      adc.valid     = 1'b0;
   endtask

   // --------------------
   // uart_txd decoder
   initial begin : uart_monitor
      logic [7:0] b;
      rx_active = 1'b0;
      forever begin
         ticks(1);
         if (arst_n === 1'b1 && uart_txd === 1'b0) begin
            rx_active = 1'b1;
            ticks(BIT_CLKS / 2);   // middle of start bit
            assert (uart_txd === 1'b0) else error_msg("uart_txd start bit too short");
            for (int i = 0; i < 8; i++) begin
               ticks(BIT_CLKS);
               b[i] = uart_txd;
            end
            ticks(BIT_CLKS);
            assert (uart_txd === 1'b1) else error_msg("uart_txd stop bit low");
            rx_q.push_back(b);
            rx_active = 1'b0;
         end
      end
   end

   // --------------------
   // main sequence
   initial begin
      seed_used = $urandom(32'h6d7bdf42);
      arst_n    = 1'b0;
      uart_rxd  = 1'b1;   // line idle
      adc       = '0;
      drv       = '0;
      ticks(8);
      arst_n = 1'b1;
      ticks(2);
      check_eq("igbt", igbt, 3'b000);
      check_eq("drv_reset", drv_reset, 3'b000);
      check_eq("uart_txd", uart_txd, 1'b1);

      // setpoints, bad header, unknown command
      send_frame(8'hA5, 8'h01, SP0);
      expect_byte(8'h01);
      send_frame(8'hA5, 8'h02, SP1);
      expect_byte(8'h02);
      send_frame(8'hA5, 8'h03, SP2);
      expect_byte(8'h03);
      send_frame(8'h5A, 8'h02, 8'h33);   // no header so all ignored
      expect_silence(400);
      send_frame(8'hA5, 8'h55, 8'h00);
      expect_byte(8'hEE);

      // start all and let only channel 1 reach its setpoint
      send_frame(8'hA5, 8'h10, 8'h07);
      wait_igbt(3'b111);
      expect_byte(8'h10);
      for (int i = 0; i < 6; i++) begin
         adc_pulse(below_sp(SP0), below_sp(SP1), below_sp(SP2));
         check_eq("igbt", igbt, 3'b111);
         ticks(3);
      end
      adc_pulse(below_sp(SP0), at_sp(SP1), below_sp(SP2));   // exactly at the setpoint
      check_eq("igbt", igbt, 3'b101);   // one cycle after valid
      expect_byte(8'h81);

      // two channels on one valid cycle
      adc_pulse(above_sp(SP0), below_sp(SP1), above_sp(SP2));
      check_eq("igbt", igbt, 3'b000);
      expect_byte(8'h80);
      expect_byte(8'h82);

      // same while the ack holds the transmitter
      send_frame(8'hA5, 8'h10, 8'h07);
      wait_igbt(3'b111);
      wait_tx_active();
      adc_pulse(above_sp(SP0), below_sp(SP1), above_sp(SP2));
      check_eq("igbt", igbt, 3'b010);
      expect_byte(8'h10);
      expect_byte(8'h80);
      expect_byte(8'h82);

      // stop without done reports
      send_frame(8'hA5, 8'h20, 8'h00);
      wait_igbt(3'b000);
      expect_byte(8'h20);
      adc_pulse(above_sp(SP0), above_sp(SP1), above_sp(SP2));
      check_eq("igbt", igbt, 3'b000);
      expect_silence(400);

      // driver fault on ch 1 and error on ch 2
      send_frame(8'hA5, 8'h10, 8'h07);
      wait_igbt(3'b111);
      expect_byte(8'h10);
      drv.fault[1] = 1'b1;
      wait_channel_off(1);
      check_eq("igbt", igbt, 3'b101);
      expect_byte(8'h91);
      drv.error[2] = 1'b1;
      wait_channel_off(2);
      check_eq("igbt", igbt, 3'b001);
      expect_byte(8'h92);
      send_frame(8'hA5, 8'h10, 8'h07);   // latched channels ignore start
      expect_byte(8'h10);
      check_eq("igbt", igbt, 3'b001);
      expect_silence(100);

      // fault gone so clear ch 1 and restart it
      drv.fault[1] = 1'b0;
      ticks(4);   // through the synchronizer
      fork
         send_frame(8'hA5, 8'h30, 8'h02);
         measure_reset(1, 16);
      join
      expect_byte(8'h30);
      send_frame(8'hA5, 8'h10, 8'h02);
      wait_igbt(3'b011);   // ch 2 error still high
      expect_byte(8'h10);

      // wind down
      send_frame(8'hA5, 8'h20, 8'h00);
      wait_igbt(3'b000);
      expect_byte(8'h20);
      drv = '0;
      expect_silence(300);
      $display("*** PASSED ***");
      $finish;
   end

endmodule

`default_nettype wire

/* cap_charge.f */
common/cap_charge_pkg.sv
uart/uart_rx.sv
uart/uart_tx.sv
uart/tx_arbiter.sv
hdl/cmd_parser.sv
hdl/charge_ctrl.sv
hdl/event_reporter.sv
hdl/cap_charge_top.sv
bench/tb_cap_charge.sv
